// ==== rvPipe_cfg.svh ====
// Core sizes for the pipelined RV32I subset core
// Data width, memory depths and fetch address after reset
`ifndef RVPIPE_CFG_SVH
`define RVPIPE_CFG_SVH

// Data and address width
`define XLEN 32

// Instruction memory depth in words
`define IMEM_WORDS 256

// Data memory depth in words
`define DMEM_WORDS 256

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== rvPipePkg.sv ====
// Shared types for the pipelined core
// Opcodes, funct3 codes, ALU and mux selects, instruction views, control structs
`include "rvPipe_cfg.svh"

package rvPipePkg;

    // Supported major opcodes
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRtype  = 7'b0110011,
        opItype  = 7'b0010011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcode_t;

    // funct3 codes for ALU ops and branches
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Bne    = 3'b001;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrl_t;

    // Operand source in Execute
    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } forwardSel_t;

    // Writeback value select
    typedef enum logic [1:0] {
        resAlu   = 2'b00,
        resLoad  = 2'b01,
        resPc4   = 2'b10,
        resUpper = 2'b11
    } resultSrc_t;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrc_t;

    // Field layouts of one instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
        bType_t b;
    } instr_u;

    // Hazard unit outputs
    typedef struct packed {
        logic        stallF;
        logic        stallD;
        logic        flushD;
        logic        flushE;
        forwardSel_t forwardA;
        forwardSel_t forwardB;
    } hazardCtrl_t;

    // Control used inside Execute
    typedef struct packed {
        aluCtrl_t aluControl;
        logic     aluSrc;
        logic     jalr;
    } execCtrl_t;

    // Word address plus data
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } memWrite_t;

endpackage

// ==== rvMemory.sv ====
// Word-addressed memory
// Combinational read port, write on the rising edge
`timescale 1ns/1ps
`include "rvPipe_cfg.svh"

module rvMemory
    import rvPipePkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] rdAddr_i,
    output logic [`XLEN-1:0] rdData_o,
    input  logic             wrValid_i,
    input  memWrite_t        wr_i
);

    localparam int AW = $clog2(DEPTH);

    logic [`XLEN-1:0] mem [DEPTH];

    // Read answers in the same cycle
    assign rdData_o = mem[rdAddr_i[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wrValid_i) begin
            mem[wr_i.addr[AW-1:0]] <= wr_i.data;
        end
    end

    // Writes never wrap around the array
    assert property (@(posedge clk) wrValid_i |-> (wr_i.addr < DEPTH));

    // Strobe must be known once the pipeline runs
    assert property (@(posedge clk) disable iff (reset) !$isunknown(wrValid_i));

endmodule

// ==== rvController.sv ====
// Control and hazard unit of the pipelined core
// Main and ALU decoder, control pipeline, branch decision
// Forwarding selects, load-use stall and flushes
`timescale 1ns/1ps

module rvController
    import rvPipePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  instr_u      instrD_i,
    input  logic        zeroE_i,
    input  logic [4:0]  rs1E_i,
    input  logic [4:0]  rs2E_i,
    input  logic [4:0]  rdE_i,
    input  logic [4:0]  rdM_i,
    input  logic [4:0]  rdW_i,
    output immSrc_t     immSrcD_o,
    output execCtrl_t   execCtrlE_o,
    output logic        pcSrcE_o,
    output hazardCtrl_t hazard_o,
    output logic        memWriteM_o,
    output logic        regWriteW_o,
    output resultSrc_t  resultSrcW_o
);

    logic       regWriteD;
    logic       memWriteD;
    logic       aluSrcD;
    logic       branchD;
    logic       jumpD;
    logic       jalrD;
    logic       subD;
    resultSrc_t resultSrcD;
    aluCtrl_t   aluControlD;
    aluCtrl_t   funcAluD;

    logic       regWriteE;
    logic       memWriteE;
    logic       branchE;
    logic       bneE;
    logic       jumpE;
    resultSrc_t resultSrcE;

    logic       regWriteM;
    resultSrc_t resultSrcM;

    logic       lwStall;
    logic [4:0] rs1D;
    logic [4:0] rs2D;

    // Forward from Memory first, then Writeback
    function automatic forwardSel_t fwdSelect(input logic [4:0] rs);
        if (rs != 5'd0 && rs == rdM_i && regWriteM) begin
            return fwdMem;
        end
        if (rs != 5'd0 && rs == rdW_i && regWriteW_o) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign rs1D = instrD_i.r.rs1;
    assign rs2D = instrD_i.r.rs2;

    // Bit 5 of funct7 selects sub, R-type only
    assign subD = instrD_i.r.funct7[5] && (instrD_i.r.opcode == opRtype);

    // ALU decoder for R-type and I-type ALU forms
    always_comb begin
        case (instrD_i.r.funct3)
            f3AddSub: funcAluD = subD ? aluSub : aluAdd;
            f3Slt:    funcAluD = aluSlt;
            f3Or:     funcAluD = aluOr;
            f3And:    funcAluD = aluAnd;
            default:  funcAluD = aluAdd;
        endcase
    end

    // Main decoder, unknown opcodes become a bubble
    always_comb begin
        regWriteD   = 1'b0;
        memWriteD   = 1'b0;
        aluSrcD     = 1'b0;
        branchD     = 1'b0;
        jumpD       = 1'b0;
        jalrD       = 1'b0;
        resultSrcD  = resAlu;
        immSrcD_o   = immI;
        aluControlD = aluAdd;
        case (instrD_i.r.opcode)
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = resLoad;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD_o = immS;
            end
            opRtype: begin
                regWriteD   = 1'b1;
                aluControlD = funcAluD;
            end
            opItype: begin
                regWriteD   = 1'b1;
                aluSrcD     = 1'b1;
                aluControlD = funcAluD;
            end
            opBranch: begin
                branchD     = 1'b1;
                immSrcD_o   = immB;
                aluControlD = aluSub;
            end
            opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                resultSrcD = resPc4;
                immSrcD_o  = immJ;
            end
            opJalr: begin
                // Target formed from rs1 plus immediate in Execute
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                jalrD      = 1'b1;
                resultSrcD = resPc4;
            end
            opLui: begin
                regWriteD  = 1'b1;
                resultSrcD = resUpper;
                immSrcD_o  = immU;
            end
            default: begin
                regWriteD = 1'b0;
            end
        endcase
    end

    // Execute stage, bubble on flush
    always_ff @(posedge clk) begin
        if (reset || hazard_o.flushE) begin
            regWriteE   <= 1'b0;
            memWriteE   <= 1'b0;
            branchE     <= 1'b0;
            bneE        <= 1'b0;
            jumpE       <= 1'b0;
            resultSrcE  <= resAlu;
            execCtrlE_o <= '0;
        end else begin
            regWriteE   <= regWriteD;
            memWriteE   <= memWriteD;
            branchE     <= branchD;
            bneE        <= (instrD_i.r.funct3 == f3Bne);
            jumpE       <= jumpD;
            resultSrcE  <= resultSrcD;
            execCtrlE_o <= '{aluControl: aluControlD, aluSrc: aluSrcD, jalr: jalrD};
        end
    end

    // Zero flag inverted for bne; jumps always redirect
    assign pcSrcE_o = (branchE && (zeroE_i ^ bneE)) || jumpE;

    // Memory and Writeback stages
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM    <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM   <= resAlu;
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= resAlu;
        end else begin
            regWriteM    <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM   <= resultSrcE;
            regWriteW_o  <= regWriteM;
            resultSrcW_o <= resultSrcM;
        end
    end

    // Load or lui in Execute feeding a Decode source
    // Neither result is on the Memory-stage ALU path
    assign lwStall = ((resultSrcE == resLoad) || (resultSrcE == resUpper))
                     && (rdE_i != 5'd0)
                     && ((rs1D == rdE_i) || (rs2D == rdE_i));

    assign hazard_o.stallF   = lwStall;
    assign hazard_o.stallD   = lwStall;
    assign hazard_o.flushD   = pcSrcE_o;
    assign hazard_o.flushE   = lwStall || pcSrcE_o;
    assign hazard_o.forwardA = fwdSelect(rs1E_i);
    assign hazard_o.forwardB = fwdSelect(rs2E_i);

    // Stall leaves exactly a bubble in Execute
    assert property (@(posedge clk) disable iff (reset)
        hazard_o.stallF |-> hazard_o.flushE ##1 (!regWriteE && !memWriteE));

    // x0 never picks up an in-flight result
    assert property (@(posedge clk) disable iff (reset)
        (rs1E_i == 5'd0) |-> (hazard_o.forwardA != fwdMem));

endmodule

// ==== rvDatapath.sv ====
// Datapath of the five-stage core
// PC, register file, immediates, ALU, pipeline registers
// Forwarding muxes and writeback select
`timescale 1ns/1ps
`include "rvPipe_cfg.svh"

module rvDatapath
    import rvPipePkg::*;
(
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] instrAddrF_o,
    input  logic [`XLEN-1:0] instrF_i,
    output logic [`XLEN-1:0] dataAddrM_o,
    input  logic [`XLEN-1:0] dataRdM_i,
    output memWrite_t        storeM_o,
    output instr_u           instrD_o,
    output logic             zeroE_o,
    output logic [4:0]       rs1E_o,
    output logic [4:0]       rs2E_o,
    output logic [4:0]       rdE_o,
    output logic [4:0]       rdM_o,
    output logic [4:0]       rdW_o,
    input  immSrc_t          immSrcD_i,
    input  execCtrl_t        execCtrlE_i,
    input  logic             pcSrcE_i,
    input  hazardCtrl_t      hazard_i,
    input  logic             memWriteM_i,
    input  logic             regWriteW_i,
    input  resultSrc_t       resultSrcW_i
);

    logic [`XLEN-1:0] pcF, pcPlus4F, pcNextF;
    logic [`XLEN-1:0] pcD, pcPlus4D, rd1D, rd2D, immExtD;
    logic [`XLEN-1:0] pcE, pcPlus4E, rd1E, rd2E, immExtE;
    logic [`XLEN-1:0] srcAE, srcBE, writeDataE, aluResultE, targetE;
    logic [`XLEN-1:0] aluResultM, writeDataM, pcPlus4M, immExtM;
    logic [`XLEN-1:0] aluResultW, readDataW, pcPlus4W, immExtW, resultW;
    logic [`XLEN-1:0] regFile [32];

    function automatic logic [`XLEN-1:0] fwdMux(input forwardSel_t sel,
                                                input logic [`XLEN-1:0] regVal);
        case (sel)
            fwdWb:   return resultW;
            fwdMem:  return aluResultM;
            default: return regVal;
        endcase
    endfunction

    // Fetch
    assign pcPlus4F     = pcF + `XLEN'(4);
    assign pcNextF      = pcSrcE_i ? targetE : pcPlus4F;
    assign instrAddrF_o = {2'b00, pcF[`XLEN-1:2]};

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= `RESET_PC;
        end else if (!hazard_i.stallF) begin
            pcF <= pcNextF;
        end
    end

    // Fetch to Decode, a zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (reset || hazard_i.flushD) begin
            instrD_o <= '0;
        end else if (!hazard_i.stallD) begin
            instrD_o <= instrF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hazard_i.stallD) begin
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    // Register file written on the falling edge
    always_ff @(negedge clk) begin
        if (regWriteW_i && rdW_o != 5'd0) begin
            regFile[rdW_o] <= resultW;
        end
    end

    assign rd1D = (instrD_o.r.rs1 == 5'd0) ? '0 : regFile[instrD_o.r.rs1];
    assign rd2D = (instrD_o.r.rs2 == 5'd0) ? '0 : regFile[instrD_o.r.rs2];

    // J and U pieces come out of the I view
    always_comb begin
        case (immSrcD_i)
            immI: immExtD = {{20{instrD_o.i.imm[11]}}, instrD_o.i.imm};
            immS: immExtD = {{20{instrD_o.s.immHi[6]}}, instrD_o.s.immHi, instrD_o.s.immLo};
            immB: immExtD = {{20{instrD_o.b.imm12}}, instrD_o.b.imm11,
                             instrD_o.b.imm10to5, instrD_o.b.imm4to1, 1'b0};
            immJ: immExtD = {{12{instrD_o.i.imm[11]}}, instrD_o.i.rs1, instrD_o.i.funct3,
                             instrD_o.i.imm[0], instrD_o.i.imm[10:1], 1'b0};
            immU: immExtD = {instrD_o.i.imm, instrD_o.i.rs1, instrD_o.i.funct3, 12'b0};
            default: immExtD = '0;
        endcase
    end

    // Decode to Execute
    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        pcE      <= pcD;
        pcPlus4E <= pcPlus4D;
        immExtE  <= immExtD;
        rs1E_o   <= instrD_o.r.rs1;
        rs2E_o   <= instrD_o.r.rs2;
        rdE_o    <= instrD_o.r.rd;
    end

    // Execute
    assign srcAE      = fwdMux(hazard_i.forwardA, rd1E);
    assign writeDataE = fwdMux(hazard_i.forwardB, rd2E);
    assign srcBE      = execCtrlE_i.aluSrc ? immExtE : writeDataE;

    always_comb begin
        case (execCtrlE_i.aluControl)
            aluAdd:  aluResultE = srcAE + srcBE;
            aluSub:  aluResultE = srcAE - srcBE;
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluSlt:  aluResultE = `XLEN'($signed(srcAE) < $signed(srcBE));
            default: aluResultE = '0;
        endcase
    end

    assign zeroE_o = (aluResultE == '0);

    // jalr clears bit 0 of rs1 plus immediate
    assign targetE = execCtrlE_i.jalr ? ((srcAE + immExtE) & ~`XLEN'(1))
                                      : (pcE + immExtE);

    // Execute to Memory
    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        immExtM    <= immExtE;
        rdM_o      <= rdE_o;
    end

    // Memory, word addresses toward both ports
    assign dataAddrM_o   = {2'b00, aluResultM[`XLEN-1:2]};
    assign storeM_o.addr = dataAddrM_o;
    assign storeM_o.data = writeDataM;

    // Memory to Writeback
    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW  <= dataRdM_i;
        pcPlus4W   <= pcPlus4M;
        immExtW    <= immExtM;
        rdW_o      <= rdM_o;
    end

    always_comb begin
        case (resultSrcW_i)
            resLoad:  resultW = readDataW;
            resPc4:   resultW = pcPlus4W;
            resUpper: resultW = immExtW;
            default:  resultW = aluResultW;
        endcase
    end

    // x0 reaches the ALU as zero
    assert property (@(posedge clk) disable iff (reset)
        (rs1E_o == 5'd0 && hazard_i.forwardA == fwdReg) |-> (srcAE == '0));

    // Stores leave with known address and data
    assert property (@(posedge clk) disable iff (reset)
        memWriteM_i |-> !$isunknown(storeM_o));

endmodule

// ==== rvSystem.sv ====
// Top level of the pipelined core
// Controller, datapath, instruction and data memories
// Program load port and store observation port
`timescale 1ns/1ps
`include "rvPipe_cfg.svh"

module rvSystem
    import rvPipePkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      loadValid_i,
    input  memWrite_t load_i,
    output logic      storeValid_o,
    output memWrite_t store_o
);

    logic [`XLEN-1:0] instrAddrF;
    logic [`XLEN-1:0] instrF;
    logic [`XLEN-1:0] dataAddrM;
    logic [`XLEN-1:0] dataRdM;
    instr_u           instrD;
    logic             zeroE;
    logic [4:0]       rs1E, rs2E, rdE, rdM, rdW;
    immSrc_t          immSrcD;
    execCtrl_t        execCtrlE;
    logic             pcSrcE;
    hazardCtrl_t      hazard;
    logic             regWriteW;
    resultSrc_t       resultSrcW;

    rvController i_controller (
        .clk          (clk),
        .reset        (reset),
        .instrD_i     (instrD),
        .zeroE_i      (zeroE),
        .rs1E_i       (rs1E),
        .rs2E_i       (rs2E),
        .rdE_i        (rdE),
        .rdM_i        (rdM),
        .rdW_i        (rdW),
        .immSrcD_o    (immSrcD),
        .execCtrlE_o  (execCtrlE),
        .pcSrcE_o     (pcSrcE),
        .hazard_o     (hazard),
        .memWriteM_o  (storeValid_o),
        .regWriteW_o  (regWriteW),
        .resultSrcW_o (resultSrcW)
    );

    rvDatapath i_datapath (
        .clk          (clk),
        .reset        (reset),
        .instrAddrF_o (instrAddrF),
        .instrF_i     (instrF),
        .dataAddrM_o  (dataAddrM),
        .dataRdM_i    (dataRdM),
        .storeM_o     (store_o),
        .instrD_o     (instrD),
        .zeroE_o      (zeroE),
        .rs1E_o       (rs1E),
        .rs2E_o       (rs2E),
        .rdE_o        (rdE),
        .rdM_o        (rdM),
        .rdW_o        (rdW),
        .immSrcD_i    (immSrcD),
        .execCtrlE_i  (execCtrlE),
        .pcSrcE_i     (pcSrcE),
        .hazard_i     (hazard),
        .memWriteM_i  (storeValid_o),
        .regWriteW_i  (regWriteW),
        .resultSrcW_i (resultSrcW)
    );

    // Program words arrive through the write port during reset
    rvMemory #(.DEPTH(`IMEM_WORDS)) i_imem (
        .clk       (clk),
        .reset     (reset),
        .rdAddr_i  (instrAddrF),
        .rdData_o  (instrF),
        .wrValid_i (loadValid_i),
        .wr_i      (load_i)
    );

    // Stores are also visible at the top
    rvMemory #(.DEPTH(`DMEM_WORDS)) i_dmem (
        .clk       (clk),
        .reset     (reset),
        .rdAddr_i  (dataAddrM),
        .rdData_o  (dataRdM),
        .wrValid_i (storeValid_o),
        .wr_i      (store_o)
    );

endmodule

// ==== tbRvSystem.sv ====
// Testbench for the pipelined RV32I subset system
// Program table with expected stores, loader, store monitor
// Cycle timeout and pass/fail summary
`timescale 1ns/1ps

module tbRvSystem
    import rvPipePkg::*;
;
    localparam int NT = 7;
    localparam int PROG_WORDS = 24;
    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam logic [31:0] MARKER = 32'h0000_00FC;

    logic      clk;
    logic      reset;
    logic      loadValid;
    memWrite_t load;
    logic      storeValid;
    memWrite_t store;

    string       testName [NT];
    logic [31:0] prog [NT][PROG_WORDS];
    int          nExp [NT];
    logic [31:0] expAddr [NT][8];
    logic [31:0] expData [NT][8];

    logic [31:0] rngState = 32'hfb53_e60e;
    int curT = -1;
    int curPc;
    int curS;
    int errCount = 0;
    int passCount = 0;
    int failCount = 0;
    int cycles = 0;

    rvSystem i_dut (
        .clk          (clk),
        .reset        (reset),
        .loadValid_i  (loadValid),
        .load_i       (load),
        .storeValid_o (storeValid),
        .store_o      (store)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Whole run bounded by 200 cycles per test
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= 200 * NT) begin
            $display("Timeout after %0d cycles, end-marker store never seen", cycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I encodings
    function automatic logic [31:0] aluReg(input logic [2:0] f3, input logic sub,
                                           input int rd, input int rs1, input int rs2);
        return {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] aluImm(input logic [2:0] f3, input int rd,
                                           input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] loadWord(input int rd, input int rs1,
                                             input logic [11:0] imm);
        return {imm, 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] storeWord(input int rs2, input int rs1,
                                              input logic [11:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] jumpReg(input int rd, input int rs1,
                                            input logic [11:0] imm);
        return {imm, 5'(rs1), 3'b000, 5'(rd), 7'b1100111};
    endfunction

    function automatic logic [31:0] upper(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    // Table building
    task automatic startTest(input string name);
        int k;
        curT++;
        curPc = 0;
        curS = 0;
        testName[curT] = name;
        for (k = 0; k < PROG_WORDS; k++) begin
            prog[curT][k] = NOP;
        end
    endtask

    task automatic emit(input logic [31:0] w);
        prog[curT][curPc] = w;
        curPc++;
    endtask

    task automatic expectStore(input logic [31:0] a, input logic [31:0] d);
        expAddr[curT][curS] = a;
        expData[curT][curS] = d;
        curS++;
        nExp[curT] = curS;
    endtask

    // Marker store, then spin on a jal to itself
    task automatic finishTest(input int rs2, input logic [31:0] d);
        emit(storeWord(rs2, 0, MARKER[11:0]));
        expectStore(MARKER, d);
        emit(jump(0, 0));
    endtask

    task automatic buildTable();
        logic [31:0] r;
        logic [11:0] a, b, c;
        logic [19:0] u;
        logic [31:0] va, vb, vc;
        int k;
        r = nextRand();
        a = r[11:0];
        b = r[23:12];
        r = nextRand();
        c = r[11:0];
        u = r[31:12];
        va = sext12(a);
        vb = sext12(b);
        vc = sext12(c);

        startTest("aluReg");
        emit(aluImm(3'b000, 1, 0, a));
        emit(aluImm(3'b000, 2, 0, b));
        emit(aluReg(3'b000, 1'b0, 3, 1, 2));
        emit(storeWord(3, 0, 12'd0));
        expectStore(0, va + vb);
        emit(aluReg(3'b000, 1'b1, 4, 1, 2));
        emit(storeWord(4, 0, 12'd4));
        expectStore(4, va - vb);
        emit(aluReg(3'b111, 1'b0, 5, 1, 2));
        emit(storeWord(5, 0, 12'd8));
        expectStore(8, va & vb);
        emit(aluReg(3'b110, 1'b0, 6, 1, 2));
        emit(storeWord(6, 0, 12'd12));
        expectStore(12, va | vb);
        emit(aluReg(3'b010, 1'b0, 7, 1, 2));
        emit(storeWord(7, 0, 12'd16));
        expectStore(16, {31'b0, $signed(va) < $signed(vb)});
        emit(upper(8, u));
        emit(storeWord(8, 0, 12'd20));
        expectStore(20, {u, 12'b0});
        finishTest(1, va);

        startTest("aluImm");
        emit(aluImm(3'b000, 1, 0, a));
        emit(aluImm(3'b000, 7, 1, c));
        emit(storeWord(7, 0, 12'd0));
        expectStore(0, va + vc);
        emit(aluImm(3'b010, 8, 1, c));
        emit(storeWord(8, 0, 12'd4));
        expectStore(4, {31'b0, $signed(va) < $signed(vc)});
        emit(aluImm(3'b111, 9, 1, c));
        emit(storeWord(9, 0, 12'd8));
        expectStore(8, va & vc);
        emit(aluImm(3'b110, 10, 1, c));
        emit(storeWord(10, 0, 12'd12));
        expectStore(12, va | vc);
        finishTest(1, va);

        // Distances one and two, then x0 write and read
        startTest("forward");
        emit(aluImm(3'b000, 1, 0, 12'd5));
        emit(aluImm(3'b000, 2, 1, 12'd7));
        emit(aluImm(3'b000, 3, 1, 12'd100));
        emit(aluReg(3'b000, 1'b0, 4, 2, 3));
        emit(storeWord(4, 0, 12'd0));
        expectStore(0, 117);
        emit(aluImm(3'b000, 0, 0, 12'd9));
        emit(aluReg(3'b000, 1'b0, 5, 0, 0));
        emit(storeWord(5, 0, 12'd4));
        expectStore(4, 0);
        emit(storeWord(2, 0, 12'd8));
        expectStore(8, 12);
        finishTest(3, 105);

        // Load result used right away, as ALU source and as store data
        startTest("loadUse");
        emit(aluImm(3'b000, 1, 0, 12'd40));
        emit(storeWord(1, 0, 12'd32));
        expectStore(32, 40);
        emit(loadWord(2, 0, 12'd32));
        emit(aluReg(3'b000, 1'b0, 3, 2, 1));
        emit(storeWord(3, 0, 12'd36));
        expectStore(36, 80);
        emit(loadWord(4, 0, 12'd36));
        emit(storeWord(4, 0, 12'd40));
        expectStore(40, 80);
        finishTest(1, 40);

        // Taken branches skip two stores each
        startTest("branch");
        emit(aluImm(3'b000, 1, 0, 12'd3));
        emit(aluImm(3'b000, 2, 0, 12'd3));
        emit(aluImm(3'b000, 3, 0, 12'd4));
        emit(branch(3'b000, 1, 3, 12));
        emit(storeWord(1, 0, 12'd0));
        expectStore(0, 3);
        emit(branch(3'b001, 1, 2, 12));
        emit(storeWord(2, 0, 12'd4));
        expectStore(4, 3);
        emit(branch(3'b000, 1, 2, 12));
        emit(storeWord(1, 0, 12'd8));
        emit(storeWord(1, 0, 12'd12));
        emit(branch(3'b001, 1, 3, 12));
        emit(storeWord(3, 0, 12'd16));
        emit(storeWord(3, 0, 12'd20));
        emit(storeWord(3, 0, 12'd24));
        expectStore(24, 4);
        finishTest(2, 3);

        // jal link 4, jalr from x6=32 plus 4 lands on word 9
        startTest("jump");
        emit(jump(1, 12));
        emit(storeWord(0, 0, 12'd8));
        emit(storeWord(0, 0, 12'd12));
        emit(storeWord(1, 0, 12'd0));
        expectStore(0, 4);
        emit(aluImm(3'b000, 6, 0, 12'd32));
        emit(jumpReg(7, 6, 12'd4));
        emit(storeWord(0, 0, 12'd16));
        emit(storeWord(0, 0, 12'd20));
        emit(storeWord(6, 0, 12'd40));
        emit(storeWord(7, 0, 12'd4));
        expectStore(4, 24);
        finishTest(1, 4);

        // Same program again after another reset
        startTest("rerunAluReg");
        for (k = 0; k < PROG_WORDS; k++) begin
            prog[curT][k] = prog[0][k];
        end
        for (k = 0; k < 8; k++) begin
            expAddr[curT][k] = expAddr[0][k];
            expData[curT][k] = expData[0][k];
        end
        nExp[curT] = nExp[0];
    endtask

    // Load under reset, release, collect stores up to the marker, compare
    task automatic runTest(input int t);
        logic [31:0] gotAddr[$];
        logic [31:0] gotData[$];
        bit done;
        int errBefore;
        int n;
        int k;
        errBefore = errCount;
        done = 1'b0;
        reset <= 1'b1;
        for (k = 0; k < PROG_WORDS; k++) begin
            @(posedge clk);
            loadValid <= 1'b1;
            load <= {32'(k), prog[t][k]};
            // Pipeline is cleared after the second edge
            if (k >= 2) begin
                assert (storeValid === 1'b0) else begin
                    $display("%s: a store appeared while reset was held", testName[t]);
                    errCount++;
                end
            end
        end
        @(posedge clk);
        loadValid <= 1'b0;
        @(posedge clk);
        reset <= 1'b0;
        while (!done) begin
            @(posedge clk);
            if (storeValid) begin
                gotAddr.push_back({store.addr[29:0], 2'b00});
                gotData.push_back(store.data);
                done = ({store.addr[29:0], 2'b00} == MARKER);
            end
        end
        assert (gotAddr.size() == nExp[t]) else begin
            $display("%s: %s, %0d seen where %0d were expected", testName[t],
                     (gotAddr.size() < nExp[t]) ? "too few stores" : "too many stores",
                     gotAddr.size(), nExp[t]);
            errCount++;
        end
        n = (gotAddr.size() < nExp[t]) ? gotAddr.size() : nExp[t];
        for (k = 0; k < n; k++) begin
            assert (gotAddr[k] == expAddr[t][k]) else begin
                $display("[FAIL] %s store %0d address: expected %h, actual %h",
                         testName[t], k, expAddr[t][k], gotAddr[k]);
                errCount++;
            end
            assert (gotData[k] == expData[t][k]) else begin
                $display("[FAIL] %s store %0d data: expected %h, actual %h",
                         testName[t], k, expData[t][k], gotData[k]);
                errCount++;
            end
        end
        if (errCount == errBefore) begin
            passCount++;
            $display("Test %s: passed with %0d stores", testName[t], gotAddr.size());
        end else begin
            failCount++;
            $display("Test %s: failed with %0d errors", testName[t], errCount - errBefore);
        end
    endtask

    initial begin
        reset <= 1'b1;
        loadValid <= 1'b0;
        load <= '0;
        buildTable();
        for (int t = 0; t < NT; t++) begin
            runTest(t);
        end
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== rvPipe.f ====
+incdir+.
rvPipePkg.sv
rvMemory.sv
rvController.sv
rvDatapath.sv
rvSystem.sv
tbRvSystem.sv

// ==== Bender.yml ====
package:
  name: rvPipe

export_include_dirs:
  - .

sources:
  - rvPipePkg.sv
  - rvMemory.sv
  - rvController.sv
  - rvDatapath.sv
  - rvSystem.sv
  - target: simulation
    files:
      - tbRvSystem.sv
